// File: all.f
board_pkg.sv
fpga_reset.sv
blinky.sv
board_regs.sv
gpio_pads.sv
led_pwm.sv
board_top.sv
tb_board_top.sv

// File: Bender.yml
package:
  name: board_shell

sources:
  - board_pkg.sv
  - fpga_reset.sv
  - blinky.sv
  - board_regs.sv
  - gpio_pads.sv
  - led_pwm.sv
  - board_top.sv
  - target: test
    files:
      - tb_board_top.sv

// File: tb_board_top.sv
////////////////////
// Testbench for the board shell, run as the top module of the simulation
// Builds stimulus tables per behaviour and applies them through the register port
////////////////////

`timescale 1ns/1ps

module tb_board_top;

	typedef enum logic [1:0] {CHK_NONE, CHK_RDATA, CHK_PADS} chk_e;

	// One table row, applied for a single clock
	typedef struct packed {
		board_pkg::reg_req_t          req;
		logic [board_pkg::GPIO_W-1:0] pad_val;  // Value the external pad drivers put out
		logic [board_pkg::GPIO_W-1:0] pad_en;   // Per-bit enable of the external drivers
		logic [board_pkg::GPIO_W-1:0] expected; // Checked one cycle after the row is applied
		chk_e                         chk;
	} step_t;

	logic                         clk;
	logic                         rst_n;
	board_pkg::reg_req_t          req;
	logic [board_pkg::GPIO_W-1:0] rdata;
	logic                         ready;
	logic                         heartbeat;
	logic                         led_r;
	logic                         led_g;
	logic                         led_b;
	wire  [board_pkg::GPIO_W-1:0] gpio;
	logic [board_pkg::GPIO_W-1:0] pad_val;
	logic [board_pkg::GPIO_W-1:0] pad_en;
	logic [board_pkg::GPIO_W-1:0] cur_pad_val; // Pad drive given to rows as they are built
	logic [board_pkg::GPIO_W-1:0] cur_pad_en;
	step_t                        table_q[$];
	integer                       seed;

	board_top i_board_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.rdata     (rdata),
		.ready     (ready),
		.heartbeat (heartbeat),
		.led_r     (led_r),
		.led_g     (led_g),
		.led_b     (led_b),
		.gpio      (gpio)
	);

	// Outside world on the pins, one tristate driver per bit
	for (genvar i = 0; i < board_pkg::GPIO_W; i++) begin : g_pad_drv
		assign gpio[i] = pad_en[i] ? pad_val[i] : 1'bz;
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 100 MHz
	end

	task automatic report_mismatch(input string msg);
		$display("Fail at time %0t: %s", $time, msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_rdata(input logic [board_pkg::GPIO_W-1:0] exp,
		input board_pkg::reg_addr_e addr);
		if (rdata !== exp)
			report_mismatch($sformatf("read of %s gave %h, expected %h", addr.name(), rdata, exp));
	endtask

	task automatic check_pads(input logic [board_pkg::GPIO_W-1:0] exp);
		if (gpio !== exp)
			report_mismatch($sformatf("pads are %b, expected %b", gpio, exp));
	endtask

	// Counts high cycles of every LED over one full PWM period
	task automatic check_duty(input board_pkg::led_duty_t exp);
		int n_r;
		int n_g;
		int n_b;
		n_r = 0;
		n_g = 0;
		n_b = 0;
		repeat (2) @(posedge clk); // Duty register then the registered compare
		repeat (256) begin
			@(posedge clk);
			#1;
			n_r += led_r;
			n_g += led_g;
			n_b += led_b;
		end
		if (n_r != exp.r) report_mismatch($sformatf("red high %0d cycles, expected %0d", n_r, exp.r));
		if (n_g != exp.g) report_mismatch($sformatf("green high %0d cycles, expected %0d", n_g, exp.g));
		if (n_b != exp.b) report_mismatch($sformatf("blue high %0d cycles, expected %0d", n_b, exp.b));
	endtask

	task automatic check_interval(input int got, input int exp);
		if (got != exp)
			report_mismatch($sformatf("heartbeat toggled after %0d cycles, expected %0d", got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
	endtask

	function automatic void push_step(input board_pkg::reg_req_t r,
		input logic [board_pkg::GPIO_W-1:0] exp, input chk_e chk);
		step_t s;
		s.req      = r;
		s.pad_val  = cur_pad_val;
		s.pad_en   = cur_pad_en;
		s.expected = exp;
		s.chk      = chk;
		table_q.push_back(s);
	endfunction

	function automatic void push_write(input board_pkg::reg_addr_e addr,
		input logic [board_pkg::GPIO_W-1:0] data);
		board_pkg::reg_req_t r;
		r       = '0;
		r.wen   = 1'b1;
		r.addr  = addr;
		r.wdata = data;
		push_step(r, '0, CHK_NONE);
	endfunction

	function automatic void push_read(input board_pkg::reg_addr_e addr,
		input logic [board_pkg::GPIO_W-1:0] exp);
		board_pkg::reg_req_t r;
		r      = '0;
		r.ren  = 1'b1;
		r.addr = addr;
		push_step(r, exp, CHK_RDATA);
	endfunction

	function automatic void push_idle();
		push_step('0, '0, CHK_NONE);
	endfunction

	function automatic void push_pad_check(input logic [board_pkg::GPIO_W-1:0] exp);
		push_step('0, exp, CHK_PADS);
	endfunction

	function automatic void set_pads(input logic [board_pkg::GPIO_W-1:0] val,
		input logic [board_pkg::GPIO_W-1:0] en);
		cur_pad_val = val; // Takes effect from the next row pushed
		cur_pad_en  = en;
	endfunction

	// A real pad enabled for output shows the output bit, anything else floats
	function automatic logic [board_pkg::GPIO_W-1:0] pad_expect(
		input logic [board_pkg::GPIO_W-1:0] out, input logic [board_pkg::GPIO_W-1:0] oe);
		logic [board_pkg::GPIO_W-1:0] e;
		for (int i = 0; i < board_pkg::GPIO_W; i++)
			e[i] = (board_pkg::GPIO_IS_PAD[i] && oe[i]) ? out[i] : 1'bz;
		return e;
	endfunction

	// Real pads read what the outside drives, internal bits read the output register
	function automatic logic [board_pkg::GPIO_W-1:0] in_expect(
		input logic [board_pkg::GPIO_W-1:0] pins, input logic [board_pkg::GPIO_W-1:0] out);
		logic [board_pkg::GPIO_W-1:0] e;
		for (int i = 0; i < board_pkg::GPIO_W; i++)
			e[i] = board_pkg::GPIO_IS_PAD[i] ? pins[i] : out[i];
		return e;
	endfunction

	task automatic check_step(input step_t s);
		case (s.chk)
			CHK_RDATA: check_rdata(s.expected, s.req.addr);
			CHK_PADS:  check_pads(s.expected);
			default:   ;
		endcase
	endtask

	// Applies the table one row per clock, each row checked on the following clock
	task automatic run_table();
		step_t prev;
		prev = '0;
		foreach (table_q[k]) begin
			@(posedge clk);
			#1;
			check_step(prev);
			req     = table_q[k].req;
			pad_val = table_q[k].pad_val;
			pad_en  = table_q[k].pad_en;
			prev    = table_q[k];
		end
		@(posedge clk);
		#1;
		check_step(prev);
		req = '0;
		table_q.delete();
	endtask

	task automatic wait_ready(input logic level);
		int n;
		n = 0;
		while (ready !== level) begin
			@(posedge clk);
			#1;
			n++;
			if (n > 1000) report_timeout($sformatf("ready to become %b", level));
		end
	endtask

	// Returns the clocks until heartbeat next changes
	task automatic measure_toggle(output int cycles);
		logic prev;
		int   n;
		prev = heartbeat;
		n    = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
			if (n > 4 * board_pkg::BLINK_HALF) report_timeout("a heartbeat toggle");
		end while (heartbeat === prev);
		cycles = n;
	endtask

	task automatic reset_dut();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		wait_ready(1'b0); // Internal reset must follow the board reset down
		rst_n = 1'b1;
		wait_ready(1'b1);
	endtask

	task automatic check_reset_state();
		check_bit("heartbeat", heartbeat, 1'b0);
		set_pads('0, '0);
		for (int k = 0; k < 6; k++)
			if (k != int'(board_pkg::REG_GPIO_IN)) push_read(board_pkg::reg_addr_e'(k), '0);
		push_pad_check({board_pkg::GPIO_W{1'bz}}); // Nothing drives any pin
		set_pads('0, '1); // Pins held low from outside so the input word is defined
		repeat (3) push_idle();
		push_read(board_pkg::REG_GPIO_IN, '0);
		set_pads('0, '0);
		push_idle();
		run_table();
		check_duty('0);
	endtask

	task automatic test_readback();
		logic [board_pkg::GPIO_W-1:0] d;
		logic [board_pkg::GPIO_W-1:0] exp;
		for (int k = 0; k < 6; k++) begin
			if (k != int'(board_pkg::REG_GPIO_IN)) begin
				d   = $random(seed);
				exp = d;
				if (k >= int'(board_pkg::REG_LED_R)) begin
					exp                       = '0;
					exp[board_pkg::DUTY_W-1:0] = d[board_pkg::DUTY_W-1:0]; // Duty keeps 8 bits
				end
				push_write(board_pkg::reg_addr_e'(k), d);
				push_read(board_pkg::reg_addr_e'(k), exp);
			end
		end
		run_table();
	endtask

	task automatic test_gpio();
		logic [board_pkg::GPIO_W-1:0] v;
		logic [board_pkg::GPIO_W-1:0] o;
		logic [board_pkg::GPIO_W-1:0] d;
		set_pads('0, '0);
		v = $random(seed);
		push_write(board_pkg::REG_GPIO_OUT, v);
		push_write(board_pkg::REG_GPIO_OE, '1);
		push_pad_check(pad_expect(v, '1));
		o = $random(seed);
		push_write(board_pkg::REG_GPIO_OE, o);
		push_pad_check(pad_expect(v, o));
		push_write(board_pkg::REG_GPIO_OE, '0);
		push_pad_check(pad_expect(v, '0));
		repeat (4) begin
			v = $random(seed);
			d = $random(seed);
			push_write(board_pkg::REG_GPIO_OUT, v);
			set_pads(d, '1); // Pins change here, read issued three rows on
			repeat (3) push_idle();
			push_read(board_pkg::REG_GPIO_IN, in_expect(d, v));
		end
		set_pads('0, '0);
		push_idle();
		run_table();
	endtask

	task automatic test_pwm();
		board_pkg::led_duty_t d;
		d = $random(seed);
		push_write(board_pkg::REG_GPIO_OUT, 16'h0001); // Green enabled
		push_write(board_pkg::REG_LED_R, {8'ha5, d.r}); // Upper byte is dropped
		push_write(board_pkg::REG_LED_G, {8'h5a, d.g});
		push_write(board_pkg::REG_LED_B, {8'hff, d.b});
		run_table();
		check_duty(d);
		push_write(board_pkg::REG_GPIO_OUT, 16'h0000);
		run_table();
		d.g = '0; // Gated off by bit 0
		check_duty(d);
	endtask

	task automatic test_heartbeat();
		int n;
		measure_toggle(n); // Aligns to the first edge
		repeat (4) begin
			measure_toggle(n);
			check_interval(n, board_pkg::BLINK_HALF);
		end
	endtask

	initial begin
		seed        = 18913;
		rst_n       = 1'b0;
		req         = '0;
		pad_val     = '0;
		pad_en      = '0;
		cur_pad_val = '0;
		cur_pad_en  = '0;
		reset_dut();
		check_reset_state();
		test_readback();
		test_gpio();
		test_pwm();
		test_heartbeat();
		push_write(board_pkg::REG_GPIO_OUT, '1); // Leave state behind for the second reset
		push_write(board_pkg::REG_GPIO_OE, '1);
		run_table();
		reset_dut();
		check_reset_state();
		$display("test passed");
		$finish;
	end

endmodule

// File: board_top.sv
////////////////////
// Board level shell of the console, with a strobe register port in place of the core
////////////////////

`timescale 1ns/1ps

module board_top (
	input  logic                         clk,
	input  logic                         rst_n,     // Board reset button
	input  board_pkg::reg_req_t          req,
	output logic [board_pkg::GPIO_W-1:0] rdata,
	output logic                         ready,     // High once the internal reset lifts
	output logic                         heartbeat,
	output logic                         led_r,
	output logic                         led_g,
	output logic                         led_b,
	inout  wire  [board_pkg::GPIO_W-1:0] gpio      // UART, LCD and flash pins live here
);

	logic                         sys_rst_n;
	logic [board_pkg::GPIO_W-1:0] gpio_out;
	logic [board_pkg::GPIO_W-1:0] gpio_oe;
	logic [board_pkg::GPIO_W-1:0] gpio_in;
	board_pkg::led_duty_t         duty;
	logic                         led_en;

	assign ready = sys_rst_n;

	// Reset stretch covers the block RAM settle time on the real part
	fpga_reset i_fpga_reset (
		.clk       (clk),
		.rst_n     (rst_n),
		.sys_rst_n (sys_rst_n)
	);

	blinky #(
		.HALF_PERIOD (board_pkg::BLINK_HALF)
	) i_blinky (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.heartbeat (heartbeat)
	);

	board_regs i_board_regs (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.req       (req),
		.gpio_in   (gpio_in),
		.rdata     (rdata),
		.gpio_out  (gpio_out),
		.gpio_oe   (gpio_oe),
		.duty      (duty),
		.led_en    (led_en)
	);

	gpio_pads i_gpio_pads (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.gpio_out  (gpio_out),
		.gpio_oe   (gpio_oe),
		.gpio      (gpio),
		.gpio_in   (gpio_in)
	);

	// Plain PWM outputs stand in for the vendor RGB current driver
	led_pwm i_led_pwm (
		.clk       (clk),
		.sys_rst_n (sys_rst_n),
		.duty      (duty),
		.led_en    (led_en),
		.led_r     (led_r),
		.led_g     (led_g),
		.led_b     (led_b)
	);

endmodule

// File: led_pwm.sv
////////////////////
// Three channel PWM for the RGB LED, all colours sharing one free running counter
////////////////////

`timescale 1ns/1ps

module led_pwm (
	input  logic                 clk,
	input  logic                 sys_rst_n,
	input  board_pkg::led_duty_t duty,
	input  logic                 led_en,  // Green enable from GPIO bit 0
	output logic                 led_r,
	output logic                 led_g,
	output logic                 led_b
);

	logic [board_pkg::DUTY_W-1:0] cnt; // Wraps every 256 clocks

	always_ff @(posedge clk) begin
		if (!sys_rst_n) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Each output is high while the counter sits below its duty,
	// so one full counter period gives exactly duty high cycles
	always_ff @(posedge clk) begin
		if (!sys_rst_n) begin
			led_r <= 1'b0;
			led_g <= 1'b0;
			led_b <= 1'b0;
		end else begin
			led_r <= cnt < duty.r;
			led_g <= (cnt < duty.g) && led_en; // Green follows the GPIO LED enable as well
			led_b <= cnt < duty.b;
		end
	end

endmodule

// File: gpio_pads.sv
////////////////////
// Bidirectional GPIO pad ring with input synchronisers and the pad mask
////////////////////

`timescale 1ns/1ps

module gpio_pads (
	input  logic                         clk,
	input  logic                         sys_rst_n,
	input  logic [board_pkg::GPIO_W-1:0] gpio_out,
	input  logic [board_pkg::GPIO_W-1:0] gpio_oe,  // 1 drives the pad
	inout  wire  [board_pkg::GPIO_W-1:0] gpio,
	output logic [board_pkg::GPIO_W-1:0] gpio_in   // Masked, synchronised pad word
);

	logic [board_pkg::GPIO_W-1:0] sync1_q; // First stage may go metastable
	logic [board_pkg::GPIO_W-1:0] sync2_q;

	// Tristate drivers
	// Only bits marked in GPIO_IS_PAD ever reach a physical pad
	for (genvar i = 0; i < board_pkg::GPIO_W; i++) begin : g_pad
		if (board_pkg::GPIO_IS_PAD[i]) begin : g_real
			assign gpio[i] = gpio_oe[i] ? gpio_out[i] : 1'bz; // Released when oe is clear
		end else begin : g_internal
			assign gpio[i] = 1'bz; // Internal bit, the pin is left to the outside
		end
	end

	// Two flop synchroniser on every pad
	always_ff @(posedge clk) begin
		if (!sys_rst_n) begin
			sync1_q <= '0;
			sync2_q <= '0;
		end else begin
			sync1_q <= gpio;
			sync2_q <= sync1_q;
		end
	end

	// Internal bits read back the output register instead of a pin
	assign gpio_in = (sync2_q & board_pkg::GPIO_IS_PAD) |
		(gpio_out & ~board_pkg::GPIO_IS_PAD);

endmodule

// File: board_regs.sv
////////////////////
// Register block behind the strobe port, holding GPIO out/oe and the LED duties
// Writes land on the next edge, and read data is registered one cycle after ren
////////////////////

`timescale 1ns/1ps

module board_regs (
	input  logic                              clk,
	input  logic                              sys_rst_n,
	input  board_pkg::reg_req_t               req,
	input  logic [board_pkg::GPIO_W-1:0]      gpio_in,  // Synchronised pad word
	output logic [board_pkg::GPIO_W-1:0]      rdata,
	output logic [board_pkg::GPIO_W-1:0]      gpio_out,
	output logic [board_pkg::GPIO_W-1:0]      gpio_oe,
	output board_pkg::led_duty_t              duty,
	output logic                              led_en    // GPIO bit 0 gates the green LED
);

	// Full register word, duty values are zero extended into it on reads
	typedef logic [board_pkg::GPIO_W-1:0] word_t;

	assign led_en = gpio_out[0];

	// Write decode
	// Accesses during internal reset are dropped by the reset branch
	always_ff @(posedge clk) begin
		if (!sys_rst_n) begin
			gpio_out <= '0;
			gpio_oe  <= '0;
			duty     <= '0; // All LEDs dark until software sets a duty
		end else if (req.wen) begin
			case (req.addr)
				board_pkg::REG_GPIO_OUT: gpio_out <= req.wdata;
				board_pkg::REG_GPIO_OE:  gpio_oe  <= req.wdata;
				// Duty registers keep only the low DUTY_W bits of the word
				board_pkg::REG_LED_R: duty.r <= req.wdata[board_pkg::DUTY_W-1:0];
				board_pkg::REG_LED_G: duty.g <= req.wdata[board_pkg::DUTY_W-1:0];
				board_pkg::REG_LED_B: duty.b <= req.wdata[board_pkg::DUTY_W-1:0];
				default: ; // REG_GPIO_IN is read only and unused codes do nothing
			endcase
		end
	end

	// Read data path
	// rdata holds its last value between reads
	always_ff @(posedge clk) begin
		if (!sys_rst_n) begin
			rdata <= '0;
		end else if (req.ren) begin
			case (req.addr)
				board_pkg::REG_GPIO_OUT: rdata <= gpio_out;
				board_pkg::REG_GPIO_OE:  rdata <= gpio_oe;
				board_pkg::REG_GPIO_IN:  rdata <= gpio_in; // Pad bits synchronised, bit 0 loops back
				board_pkg::REG_LED_R:    rdata <= word_t'(duty.r);
				board_pkg::REG_LED_G:    rdata <= word_t'(duty.g);
				board_pkg::REG_LED_B:    rdata <= word_t'(duty.b);
				default:                 rdata <= '0; // Unmapped addresses read as zero
			endcase
		end
	end

	// The port has no arbitration, so a read and a write in one cycle would be lost
	a_no_wen_ren : assert property (
		@(posedge clk) disable iff (!sys_rst_n)
		!(req.wen && req.ren)
	) else $error("wen and ren high in the same cycle");

	// Pad inputs are owned by gpio_pads and software must never write them
	a_no_write_gpio_in : assert property (
		@(posedge clk) disable iff (!sys_rst_n)
		req.wen |-> (req.addr != board_pkg::REG_GPIO_IN)
	) else $error("write to the read-only REG_GPIO_IN");

	// A write must be visible to a read issued on the following cycle
	a_write_then_read : assert property (
		@(posedge clk) disable iff (!sys_rst_n)
		req.wen && (req.addr == board_pkg::REG_GPIO_OUT) ##1 req.ren &&
		(req.addr == board_pkg::REG_GPIO_OUT) |=> rdata == $past(req.wdata, 2)
	) else $error("GPIO out readback does not match the preceding write");

endmodule

// File: blinky.sv
////////////////////
// Heartbeat that toggles every HALF_PERIOD clocks once the board is out of reset
////////////////////

`timescale 1ns/1ps

module blinky #(
	parameter int HALF_PERIOD = board_pkg::BLINK_HALF // Clocks between toggles
) (
	input  logic clk,
	input  logic sys_rst_n,
	output logic heartbeat
);

	typedef logic [$clog2(HALF_PERIOD)-1:0] cnt_t;

	cnt_t cnt; // Counts down to zero then reloads

	always_ff @(posedge clk) begin
		if (!sys_rst_n) begin
			cnt       <= cnt_t'(HALF_PERIOD - 1); // First toggle lands HALF_PERIOD clocks out
			heartbeat <= 1'b0;
		end else if (cnt == '0) begin
			cnt       <= cnt_t'(HALF_PERIOD - 1);
			heartbeat <= ~heartbeat; // One toggle per reload
		end else begin
			cnt <= cnt - cnt_t'(1);
		end
	end

endmodule

// File: fpga_reset.sv
////////////////////
// Board reset generator that synchronises rst_n and stretches the release
////////////////////

`timescale 1ns/1ps

module fpga_reset (
	input  logic clk,
	input  logic rst_n,    // Board reset, may be asynchronous to clk
	output logic sys_rst_n // Internal reset for the rest of the board
);

	// Counter wide enough to reach RST_COUNT itself
	typedef logic [$clog2(board_pkg::RST_COUNT + 1)-1:0] cnt_t;

	logic [board_pkg::RST_SHIFT-1:0] sync_q; // Ones shift in after release
	cnt_t                            cnt;
	logic                            sync_rel;

	assign sync_rel = sync_q[board_pkg::RST_SHIFT-1]; // Release seen by the last stage

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[board_pkg::RST_SHIFT-2:0], 1'b1};
		end
	end

	// Count the stretch once the synchroniser has let go, and park at the end
	always_ff @(posedge clk) begin
		if (!rst_n || !sync_rel) begin
			cnt <= '0;
		end else if (cnt != cnt_t'(board_pkg::RST_COUNT)) begin
			cnt <= cnt + cnt_t'(1);
		end
	end

	// Release lands on the same edge that takes the counter to RST_COUNT
	always_ff @(posedge clk) begin
		if (!rst_n || !sync_rel) begin
			sys_rst_n <= 1'b0; // Assertion of the internal reset follows rst_n directly
		end else if (cnt == cnt_t'(board_pkg::RST_COUNT - 1)) begin
			sys_rst_n <= 1'b1;
		end
	end

	// The internal reset may only lift once the full stretch has elapsed
	a_release_after_count : assert property (
		@(posedge clk) $rose(sys_rst_n) |-> (cnt == cnt_t'(board_pkg::RST_COUNT))
	) else $error("sys_rst_n released before the stretch count finished");

endmodule

// File: board_pkg.sv
////////////////////
// Shared constants, register map and access types for the console board shell
// Every design file refers to these through board_pkg:: scoped names
////////////////////

package board_pkg;

	// GPIO word width, shared by the register port and the pad ring
	localparam int GPIO_W = 16;

	// Bit 0 is the on-board LED enable and never reaches a pad
	localparam logic [GPIO_W-1:0] GPIO_IS_PAD = 16'hfffe;

	// Cycles the internal reset is held after the synchronised release
	localparam int RST_COUNT = 200;
	localparam int RST_SHIFT = 3; // Depth of the reset synchroniser

	// Heartbeat half period in clocks, kept short so simulation sees many toggles
	localparam int BLINK_HALF = 16;

	localparam int DUTY_W = 8; // PWM duty and counter width

	// Register addresses seen on the register port
	typedef enum logic [2:0] {
		REG_GPIO_OUT = 3'd0, // Output values
		REG_GPIO_OE  = 3'd1, // Output enables, 1 drives the pad
		REG_GPIO_IN  = 3'd2, // Synchronised pad values, read only
		REG_LED_R    = 3'd3,
		REG_LED_G    = 3'd4,
		REG_LED_B    = 3'd5
	} reg_addr_e;

	// One register access, with wen and ren as single cycle strobes
	typedef struct packed {
		logic              wen;
		logic              ren;
		reg_addr_e         addr;
		logic [GPIO_W-1:0] wdata;
	} reg_req_t;

	// Duty values for the RGB LED, one per colour
	typedef struct packed {
		logic [DUTY_W-1:0] r;
		logic [DUTY_W-1:0] g;
		logic [DUTY_W-1:0] b;
	} led_duty_t;

endpackage
